/* hw/conv_pkg.sv */
// Convolution engine shared definitions
package conv_pkg;

    // Pixel and kernel coefficient width, signed
    localparam int pix_w = 16;

    // Bias and result width, signed
    localparam int acc_w = 48;

    // Output stream word
    localparam int tdata_w = 64;

    // Control FSM states
    typedef enum logic [1:0] {
        // Waiting for load_kernel
        st_idle,
        // Accepting pixels
        st_run,
        // Last pixel taken, last result still pending
        st_flush
    } conv_state_t;

endpackage

/* hw/line_buffer.sv */
// Two-row pixel line buffer
`timescale 1ns/1ps

module line_buffer
    import conv_pkg::*;
#(
    parameter int MAX_WIDTH = 64,
    localparam int col_w = $clog2(MAX_WIDTH)
) (
    input  logic                    clk,
    input  logic                    pix_accept,
    input  logic [col_w-1:0]        col,
    input  logic signed [pix_w-1:0] pixel,
    output logic signed [pix_w-1:0] row_above_1,
    output logic signed [pix_w-1:0] row_above_2
);

    // Row n-1 and row n-2 storage
    logic signed [pix_w-1:0] mem_1 [MAX_WIDTH];
    logic signed [pix_w-1:0] mem_2 [MAX_WIDTH];

    // Cascaded write, old n-1 pixel drops into n-2
    always_ff @(posedge clk) begin
        if (pix_accept) begin
            mem_1[col] <= pixel;
            mem_2[col] <= mem_1[col];
        end
    end

    // Asynchronous read at the current column
    assign row_above_1 = mem_1[col];
    assign row_above_2 = mem_2[col];

endmodule

/* hw/window_3x3.sv */
// 3x3 sliding pixel window
`timescale 1ns/1ps

module window_3x3
    import conv_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pix_accept,
    input  logic signed [pix_w-1:0] row_above_2,
    input  logic signed [pix_w-1:0] row_above_1,
    input  logic signed [pix_w-1:0] pixel,
    output logic signed [pix_w-1:0] win_00,
    output logic signed [pix_w-1:0] win_01,
    output logic signed [pix_w-1:0] win_02,
    output logic signed [pix_w-1:0] win_10,
    output logic signed [pix_w-1:0] win_11,
    output logic signed [pix_w-1:0] win_12,
    output logic signed [pix_w-1:0] win_20,
    output logic signed [pix_w-1:0] win_21,
    output logic signed [pix_w-1:0] win_22
);

    // Window cells, [row][column], row 0 oldest
    logic signed [pix_w-1:0] w [3][3];
    // Incoming column, top to bottom
    logic signed [pix_w-1:0] new_col [3];

    assign new_col[0] = row_above_2;
    assign new_col[1] = row_above_1;
    assign new_col[2] = pixel;

    // Shift left one column per accepted pixel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                for (int j = 0; j < 3; j++) begin
                    w[i][j] <= '0;
                end
            end
        end else if (pix_accept) begin
            for (int i = 0; i < 3; i++) begin
                w[i][0] <= w[i][1];
                w[i][1] <= w[i][2];
                // Newest column lands in slot 2
                w[i][2] <= new_col[i];
            end
        end
    end

    assign win_00 = w[0][0];
    assign win_01 = w[0][1];
    assign win_02 = w[0][2];
    assign win_10 = w[1][0];
    assign win_11 = w[1][1];
    assign win_12 = w[1][2];
    assign win_20 = w[2][0];
    assign win_21 = w[2][1];
    assign win_22 = w[2][2];

endmodule

/* hw/conv_pe.sv */
// 3x3 multiply-accumulate element
`timescale 1ns/1ps

module conv_pe
    import conv_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_coef,
    input  logic [9*pix_w-1:0]      kernel_flat,
    input  logic signed [acc_w-1:0] bias,
    input  logic                    load_result,
    input  logic signed [pix_w-1:0] win_00,
    input  logic signed [pix_w-1:0] win_01,
    input  logic signed [pix_w-1:0] win_02,
    input  logic signed [pix_w-1:0] win_10,
    input  logic signed [pix_w-1:0] win_11,
    input  logic signed [pix_w-1:0] win_12,
    input  logic signed [pix_w-1:0] win_20,
    input  logic signed [pix_w-1:0] win_21,
    input  logic signed [pix_w-1:0] win_22,
    output logic signed [acc_w-1:0] result
);

    // Coefficients, index i*3+j
    logic signed [pix_w-1:0]   coef [9];
    logic signed [acc_w-1:0]   bias_q;
    // Window flattened with the same indexing
    logic signed [pix_w-1:0]   px [9];
    logic signed [2*pix_w-1:0] prod [9];
    // Adder tree levels
    logic signed [acc_w-1:0]   lvl_1 [5];
    logic signed [acc_w-1:0]   lvl_2 [3];
    logic signed [acc_w-1:0]   biased;

    // Kernel and bias latch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 9; k++) begin
                coef[k] <= '0;
            end
            bias_q <= '0;
        end else if (load_coef) begin
            for (int k = 0; k < 9; k++) begin
                coef[k] <= kernel_flat[k*pix_w +: pix_w];
            end
            bias_q <= bias;
        end
    end

    assign px[0] = win_00;
    assign px[1] = win_01;
    assign px[2] = win_02;
    assign px[3] = win_10;
    assign px[4] = win_11;
    assign px[5] = win_12;
    assign px[6] = win_20;
    assign px[7] = win_21;
    assign px[8] = win_22;

    always_comb begin
        // Nine signed products
        for (int k = 0; k < 9; k++) begin
            prod[k] = px[k] * coef[k];
        end
        // Pairwise sums, sign-extended to accumulator width
        for (int k = 0; k < 4; k++) begin
            lvl_1[k] = acc_w'(prod[2*k]) + acc_w'(prod[2*k+1]);
        end
        lvl_1[4] = acc_w'(prod[8]);
        lvl_2[0] = lvl_1[0] + lvl_1[1];
        lvl_2[1] = lvl_1[2] + lvl_1[3];
        // Bias folded into the odd leaf
        lvl_2[2] = lvl_1[4] + bias_q;
        biased   = lvl_2[0] + lvl_2[1] + lvl_2[2];
    end

    // Result holds until the next window is taken
    always_ff @(posedge clk) begin
        if (load_result) begin
            result <= biased;
        end
    end

endmodule

/* hw/conv_cu.sv */
// Convolution control unit
`timescale 1ns/1ps

module conv_cu
    import conv_pkg::*;
#(
    parameter int MAX_WIDTH = 64,
    localparam int col_w = $clog2(MAX_WIDTH),
    localparam int size_w = $clog2(MAX_WIDTH + 1)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_kernel,
    input  logic [size_w-1:0] image_size,
    input  logic              s_axis_tvalid,
    input  logic              m_axis_tready,
    output logic              s_axis_tready,
    output logic              m_axis_tvalid,
    output logic              m_axis_tlast,
    output logic              pix_accept,
    output logic [col_w-1:0]  col,
    output logic              load_coef,
    output logic              load_result
);

    conv_state_t      state;
    logic [col_w-1:0] row;
    logic [col_w-1:0] last_idx;
    // Full window waiting for the PE
    logic             win_ready;
    logic             win_last;
    // Output register status
    logic             out_valid;
    logic             out_last;
    logic             res_free;
    logic             stall;
    logic             last_pix;
    logic             tlast_beat;

    assign last_idx = col_w'(image_size - size_w'(1));

    // Result register empty or draining this cycle
    assign res_free = !out_valid || m_axis_tready;
    // The one back-pressure condition
    assign stall    = win_ready && !res_free;

    assign s_axis_tready = (state == st_run) && !stall;
    assign pix_accept    = s_axis_tvalid && s_axis_tready;
    assign load_result   = win_ready && res_free;
    assign load_coef     = (state == st_idle) && load_kernel;

    assign last_pix   = (row == last_idx) && (col == last_idx);
    assign tlast_beat = out_valid && out_last && m_axis_tready;

    assign m_axis_tvalid = out_valid;
    assign m_axis_tlast  = out_last;

    // Main FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            unique case (state)
                st_idle: begin
                    if (load_kernel) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (pix_accept && last_pix) begin
                        state <= st_flush;
                    end
                end
                st_flush: begin
                    // Wait for the tlast beat to leave
                    if (tlast_beat) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Raster position of the next pixel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (pix_accept) begin
            if (col == last_idx) begin
                col <= '0;
                row <= last_pix ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Window flag, set only for unpadded positions
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_ready <= 1'b0;
            win_last  <= 1'b0;
        end else if (pix_accept) begin
            win_ready <= (row >= col_w'(2)) && (col >= col_w'(2));
            win_last  <= last_pix;
        end else if (load_result) begin
            win_ready <= 1'b0;
        end
    end

    // Output valid and last
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (load_result) begin
            out_valid <= 1'b1;
            out_last  <= win_last;
        end else if (m_axis_tready) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

endmodule

/* hw/conv_top.sv */
// 3x3 streaming convolution top
`timescale 1ns/1ps

module conv_top
    import conv_pkg::*;
#(
    parameter int MAX_WIDTH = 64,
    localparam int col_w = $clog2(MAX_WIDTH),
    localparam int size_w = $clog2(MAX_WIDTH + 1)
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // Control
    input  logic                    load_kernel,
    input  logic [size_w-1:0]       image_size,
    input  logic [9*pix_w-1:0]      kernel_flat,
    input  logic signed [acc_w-1:0] bias,
    // Pixel input stream
    input  logic signed [pix_w-1:0] s_axis_tdata,
    input  logic                    s_axis_tvalid,
    output logic                    s_axis_tready,
    // Result output stream
    output logic [tdata_w-1:0]      m_axis_tdata,
    output logic                    m_axis_tvalid,
    input  logic                    m_axis_tready,
    output logic                    m_axis_tlast
);

    // Control to datapath
    logic                    pix_accept;
    logic [col_w-1:0]        col;
    logic                    load_coef;
    logic                    load_result;

    // Line buffer taps
    logic signed [pix_w-1:0] row_above_1;
    logic signed [pix_w-1:0] row_above_2;

    // Window cells
    logic signed [pix_w-1:0] win_00, win_01, win_02;
    logic signed [pix_w-1:0] win_10, win_11, win_12;
    logic signed [pix_w-1:0] win_20, win_21, win_22;

    logic signed [acc_w-1:0] result;

    conv_cu #(
        .MAX_WIDTH(MAX_WIDTH)
    ) u_cu (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_kernel  (load_kernel),
        .image_size   (image_size),
        .s_axis_tvalid(s_axis_tvalid),
        .m_axis_tready(m_axis_tready),
        .s_axis_tready(s_axis_tready),
        .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tlast (m_axis_tlast),
        .pix_accept   (pix_accept),
        .col          (col),
        .load_coef    (load_coef),
        .load_result  (load_result)
    );

    line_buffer #(
        .MAX_WIDTH(MAX_WIDTH)
    ) u_line_buffer (
        .clk        (clk),
        .pix_accept (pix_accept),
        .col        (col),
        .pixel      (s_axis_tdata),
        .row_above_1(row_above_1),
        .row_above_2(row_above_2)
    );

    window_3x3 u_window (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_accept (pix_accept),
        .row_above_2(row_above_2),
        .row_above_1(row_above_1),
        .pixel      (s_axis_tdata),
        .win_00(win_00), .win_01(win_01), .win_02(win_02),
        .win_10(win_10), .win_11(win_11), .win_12(win_12),
        .win_20(win_20), .win_21(win_21), .win_22(win_22)
    );

    conv_pe u_pe (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_coef  (load_coef),
        .kernel_flat(kernel_flat),
        .bias       (bias),
        .load_result(load_result),
        .win_00(win_00), .win_01(win_01), .win_02(win_02),
        .win_10(win_10), .win_11(win_11), .win_12(win_12),
        .win_20(win_20), .win_21(win_21), .win_22(win_22),
        .result     (result)
    );

    // Sign-extend onto the stream word
    assign m_axis_tdata = {{(tdata_w - acc_w){result[acc_w-1]}}, result};

endmodule

/* sim/conv_assert.sv */
// Stream protocol and reset checks
`timescale 1ns/1ps

module conv_assert
    import conv_pkg::*;
(
    input logic               clk,
    input logic               rst_n,
    input logic               load_kernel,
    input logic               s_axis_tready,
    input logic [tdata_w-1:0] m_axis_tdata,
    input logic               m_axis_tvalid,
    input logic               m_axis_tready,
    input logic               m_axis_tlast
);

    int   fail_count = 0;
    // Set once the first kernel strobe is seen
    logic kernel_seen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kernel_seen <= 1'b0;
        end else if (load_kernel) begin
            kernel_seen <= 1'b1;
        end
    end

    // Outputs cleared one edge after a reset cycle
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!m_axis_tvalid && !m_axis_tlast && !s_axis_tready))
    else begin
        $error("Stream outputs not cleared after reset");
        fail_count++;
    end

    // Idle until the first kernel load
    idle_before_kernel: assert property (@(posedge clk)
        (rst_n && !kernel_seen) |-> (!m_axis_tvalid && !m_axis_tlast && !s_axis_tready))
    else begin
        $error("Stream outputs active before the first kernel load");
        fail_count++;
    end

    // Stalled result keeps valid, data and last
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
    else begin
        $error("Stalled output beat changed before transfer");
        fail_count++;
    end

endmodule

bind conv_top conv_assert u_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_kernel  (load_kernel),
    .s_axis_tready(s_axis_tready),
    .m_axis_tdata (m_axis_tdata),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tready(m_axis_tready),
    .m_axis_tlast (m_axis_tlast)
);

/* sim/conv_tb.sv */
// Convolution engine testbench
`timescale 1ns/1ps

module conv_tb
    import conv_pkg::*;
();

    localparam int max_w          = 64;
    localparam int size_w         = $clog2(max_w + 1);
    localparam int timeout_cycles = 1000;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    load_kernel;
    logic [size_w-1:0]       image_size;
    logic [9*pix_w-1:0]      kernel_flat;
    logic signed [acc_w-1:0] bias;
    logic signed [pix_w-1:0] s_axis_tdata;
    logic                    s_axis_tvalid;
    logic                    s_axis_tready;
    logic [tdata_w-1:0]      m_axis_tdata;
    logic                    m_axis_tvalid;
    logic                    m_axis_tready;
    logic                    m_axis_tlast;

    // Reference model state for images up to 8x8
    integer                  seed;
    logic signed [pix_w-1:0] img [64];
    logic signed [pix_w-1:0] coef [9];
    logic signed [acc_w-1:0] bias_val;
    logic [tdata_w-1:0]      exp_data [$];
    logic                    exp_last [$];

    int data_errors  = 0;
    int last_errors  = 0;
    int count_errors = 0;
    int idle_errors  = 0;
    int timeouts     = 0;
    int total;

    conv_top #(
        .MAX_WIDTH(max_w)
    ) uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_kernel  (load_kernel),
        .image_size   (image_size),
        .kernel_flat  (kernel_flat),
        .bias         (bias),
        .s_axis_tdata (s_axis_tdata),
        .s_axis_tvalid(s_axis_tvalid),
        .s_axis_tready(s_axis_tready),
        .m_axis_tdata (m_axis_tdata),
        .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tready(m_axis_tready),
        .m_axis_tlast (m_axis_tlast)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // Random kernel and bias latched by a one-cycle strobe
    task automatic load_new_kernel(input int n);
        logic [9*pix_w-1:0] flat;
        for (int k = 0; k < 9; k++) begin
            coef[k] = pix_w'($random(seed));
            flat[k*pix_w +: pix_w] = coef[k];
        end
        bias_val = acc_w'({$random(seed), $random(seed)});
        @(posedge clk);
        kernel_flat <= flat;
        bias        <= bias_val;
        image_size  <= size_w'(n);
        load_kernel <= 1'b1;
        @(posedge clk);
        load_kernel <= 1'b0;
    endtask

    // Correlation of each unpadded window with row 0 and column 0 oldest
    task automatic compute_expected(input int n);
        longint                  sum;
        logic signed [acc_w-1:0] wrapped;
        exp_data.delete();
        exp_last.delete();
        for (int r = 2; r < n; r++) begin
            for (int c = 2; c < n; c++) begin
                sum = longint'(bias_val);
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        sum += longint'(img[(r-2+i)*n + c-2+j]) * longint'(coef[i*3+j]);
                    end
                end
                // Result wraps at the accumulator width
                wrapped = sum[acc_w-1:0];
                // Signed cast widens onto the stream word
                exp_data.push_back(tdata_w'(wrapped));
                exp_last.push_back(r == n-1 && c == n-1);
            end
        end
    endtask

    // Raster-order pixel source holding valid until each transfer
    task automatic send_pixels(input int n);
        int wait_cycles;
        for (int p = 0; p < n*n; p++) begin
            s_axis_tdata  <= img[p];
            s_axis_tvalid <= 1'b1;
            wait_cycles = 0;
            do begin
                @(posedge clk);
                wait_cycles++;
            end while (!s_axis_tready && wait_cycles < timeout_cycles);
            if (!s_axis_tready) begin
                timeouts++;
                $display("Timeout: input stream never ready for pixel %0d", p);
                s_axis_tvalid <= 1'b0;
                return;
            end
        end
        s_axis_tvalid <= 1'b0;
    endtask

    // In-order result sink with random ready gaps
    task automatic collect_results(input int n);
        int                 wait_cycles;
        int                 got;
        logic               done;
        logic [tdata_w-1:0] want_data;
        logic               want_last;
        got = 0;
        done = 1'b0;
        wait_cycles = 0;
        while (!done) begin
            @(posedge clk);
            if (m_axis_tvalid && m_axis_tready) begin
                got++;
                wait_cycles = 0;
                if (exp_data.size() == 0) begin
                    count_errors++;
                    $display("Result %0d arrived beyond the expected count", got);
                end else begin
                    want_data = exp_data.pop_front();
                    want_last = exp_last.pop_front();
                    assert (m_axis_tdata == want_data) else begin
                        data_errors++;
                        $display("** Error m_axis_tdata: got %h, expected %h at result %0d",
                                 m_axis_tdata, want_data, got);
                    end
                    assert (m_axis_tlast == want_last) else begin
                        last_errors++;
                        $display("** Error m_axis_tlast: got %h, expected %h at result %0d",
                                 m_axis_tlast, want_last, got);
                    end
                end
                done = m_axis_tlast;
            end else begin
                wait_cycles++;
                if (wait_cycles >= timeout_cycles) begin
                    timeouts++;
                    $display("Timeout: no result after %0d cycles", wait_cycles);
                    done = 1'b1;
                end
            end
            // Roughly one stall cycle in four
            m_axis_tready <= ($random(seed) & 3) != 0;
        end
        assert (got == (n-2)*(n-2)) else begin
            count_errors++;
            $display("Wrong result count for %0dx%0d image: got %0d, expected %0d",
                     n, n, got, (n-2)*(n-2));
        end
    endtask

    // One full image with a fresh kernel
    task automatic run_image(input int n);
        if (timeouts != 0) begin
            return;
        end
        for (int p = 0; p < n*n; p++) begin
            img[p] = pix_w'($random(seed));
        end
        load_new_kernel(n);
        compute_expected(n);
        fork
            send_pixels(n);
            collect_results(n);
        join
        // Back in idle with input closed and nothing left to send
        @(posedge clk);
        assert (!s_axis_tready) else begin
            idle_errors++;
            $display("** Error s_axis_tready: got %h, expected %h in idle", s_axis_tready, 1'b0);
        end
        assert (!m_axis_tvalid) else begin
            count_errors++;
            $display("** Error m_axis_tvalid: got %h, expected %h after tlast",
                     m_axis_tvalid, 1'b0);
        end
    endtask

    initial begin
        seed          = 32'h19b5102f;
        rst_n         = 1'b0;
        load_kernel   = 1'b0;
        image_size    = '0;
        kernel_flat   = '0;
        bias          = '0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // Some idle cycles before the first kernel
        repeat (3) @(posedge clk);
        run_image(4);
        run_image(8);
        run_image(4);
        total = data_errors + last_errors + count_errors + idle_errors + timeouts
              + uut.u_assert.fail_count;
        $display("Error counts: data %0d, last %0d, count %0d, idle %0d, timeout %0d, assert %0d",
                 data_errors, last_errors, count_errors, idle_errors, timeouts,
                 uut.u_assert.fail_count);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* src.f */
hw/conv_pkg.sv
hw/line_buffer.sv
hw/window_3x3.sv
hw/conv_pe.sv
hw/conv_cu.sv
hw/conv_top.sv
sim/conv_assert.sv
sim/conv_tb.sv

/* Makefile */
# Verilator build and run of the convolution engine testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on reported errors"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module conv_tb -Mdir obj_dir
	./obj_dir/Vconv_tb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir $(LOG)
